// ==== div32_unit.f ====
+incdir+include
rtl/g729_types_pkg.sv
rtl/basic_op_pkg.sv
rtl/basic_op_if.sv
rtl/basic_op_alu.sv
rtl/div_s_iter.sv
rtl/dpf_mult.sv
rtl/div32_ctrl.sv
rtl/div32_unit.sv
tests/div32_asserts.sv
tests/tb_div32.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_div32 -Mdir obj_dir -f div32_unit.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_div32
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation run ended with status $status"
	exit $status
fi

exit 0

// ==== tests/tb_div32.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "g729_cfg.svh"

module tb_div32;
	import g729_types_pkg::*;

	localparam int clock_period = 4;
	localparam int n_random = 2000;
	localparam int n_zero = 16;
	localparam int n_near = 200;
	localparam int n_busy = 64;
	localparam int max_latency = 40;
	localparam int watchdog_cycles =
		10 + (n_random + n_zero + n_near + n_busy) * max_latency + 200;

	logic clock = 1'b0;
	logic reset;
	logic start;
	logic [31:0] numerator;
	logic [31:0] denominator;
	logic busy;
	logic done;
	logic [31:0] quotient;
	logic overflow;

	int accepted_count = 0;
	int done_count = 0;
	logic [31:0] held_quotient = '0;
	logic held_overflow = 1'b0;

	div32_unit div32_unit_inst (
		.clock(clock),
		.reset(reset),
		.start(start),
		.numerator(numerator),
		.denominator(denominator),
		.busy(busy),
		.done(done),
		.quotient(quotient),
		.overflow(overflow)
	);

	bind div32_ctrl div32_asserts div32_asserts_inst (
		.clock(clock),
		.reset(reset),
		.start(start),
		.busy(busy),
		.done(done),
		.div_start(div_start),
		.mul_start(mul_start)
	);

	initial begin
		forever #(clock_period / 2) clock = ~clock;
	end

	task automatic flag_mismatch(input string what);
		$display("Error at time %0t: %s", $time, what);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	initial begin
		#(watchdog_cycles * clock_period);
		abort_run("Watchdog expired before all divisions finished");
	end

	// Failures of the bound protocol assertions
	always @(negedge clock) begin
		assert (div32_unit_inst.div32_ctrl_inst.div32_asserts_inst.failures == 0)
			else abort_run("Protocol assertion failed in the controller");
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic word32_t clamp_32(input longint value);
		if (value > longint'(`G729_MAX_32))
			return `G729_MAX_32;
		if (value < longint'(`G729_MIN_32))
			return `G729_MIN_32;
		return value[31:0];
	endfunction

	// L_mult
	function automatic word32_t long_mult(input word16_t x, input word16_t y);
		longint p;
		p = longint'(x) * longint'(y);
		return clamp_32(p * 2);
	endfunction

	function automatic word32_t long_mac(input word32_t acc, input word16_t x, input word16_t y);
		return clamp_32(longint'(acc) + longint'(long_mult(x, y)));
	endfunction

	// mult, Q15 product
	function automatic word16_t short_mult(input word16_t x, input word16_t y);
		longint p;
		p = (longint'(x) * longint'(y)) >>> 15;
		if (p > 64'sd32767)
			return 16'sh7FFF;
		if (p < -64'sd32768)
			return 16'sh8000;
		return p[15:0];
	endfunction

	// div_s, one quotient bit per pass
	function automatic word16_t seed_div(input word16_t num, input word16_t den);
		longint rem;
		word16_t q;
		int i;
		if (num == den)
			return 16'sh7FFF;
		rem = longint'(num);
		q = '0;
		for (i = 0; i < `G729_DIV_BITS; i++) begin
			rem = rem * 2;
			q = q <<< 1;
			if (rem >= longint'(den)) begin
				rem = rem - longint'(den);
				q = q + 16'sd1;
			end
		end
		return q;
	endfunction

	// L_Extract
	task automatic split_dpf(input word32_t value, output word16_t hi, output word16_t lo);
		longint rest;
		hi = value[31:16];
		rest = (longint'(value) >>> 1) - longint'(hi) * 64'sd32768;
		lo = rest[15:0];
	endtask

	// L_shl by two with overflow
	task automatic shift_left_two(input word32_t value, output word32_t result, output logic ovf);
		int i;
		result = value;
		ovf = 1'b0;
		for (i = 0; i < 2; i++) begin
			if (!ovf && result > 32'sh3FFF_FFFF) begin
				result = `G729_MAX_32;
				ovf = 1'b1;
			end else if (!ovf && result < 32'shC000_0000) begin
				result = `G729_MIN_32;
				ovf = 1'b1;
			end else if (!ovf) begin
				result = result <<< 1;
			end
		end
	endtask

	task automatic predict_div32(input word32_t num, input word32_t den,
			output word32_t q, output logic ovf);
		word16_t den_hi;
		word16_t den_lo;
		word16_t num_hi;
		word16_t num_lo;
		word16_t approx;
		word16_t hi;
		word16_t lo;
		word32_t l32;
		split_dpf(den, den_hi, den_lo);
		split_dpf(num, num_hi, num_lo);
		approx = seed_div(`G729_RECIP_SEED, den_hi);
		// Newton step on the reciprocal
		l32 = long_mac(long_mult(den_hi, approx), short_mult(den_lo, approx), 16'sd1);
		l32 = clamp_32(longint'(`G729_MAX_32) - longint'(l32));
		split_dpf(l32, hi, lo);
		l32 = long_mac(long_mult(hi, approx), short_mult(lo, approx), 16'sd1);
		split_dpf(l32, hi, lo);
		// Full 32 by 32 product with the numerator
		l32 = long_mult(num_hi, hi);
		l32 = long_mac(l32, short_mult(num_hi, lo), 16'sd1);
		l32 = long_mac(l32, short_mult(num_lo, hi), 16'sd1);
		shift_left_two(l32, q, ovf);
	endtask

	//////////////////////////////
	// Stimulus and checks
	//////////////////////////////

	function automatic logic [31:0] random_denominator();
		return 32'h4000_0000 | ($urandom & 32'h3FFF_FFFF);
	endfunction

	// Counts done strobes, outputs must hold between them
	always @(negedge clock) begin
		if (!reset) begin
			if (done) begin
				done_count = done_count + 1;
				held_quotient = quotient;
				held_overflow = overflow;
			end else begin
				assert (quotient == held_quotient && overflow == held_overflow)
					else flag_mismatch("quotient or overflow changed without done");
			end
		end
	end

	task automatic run_division(input logic [31:0] num, input logic [31:0] den,
			input logic extra_starts);
		word32_t expect_q;
		logic expect_ovf;
		int cycles;
		logic finished;
		predict_div32(num, den, expect_q, expect_ovf);
		@(posedge clock);
		start <= 1'b1;
		numerator <= num;
		denominator <= den;
		@(posedge clock);
		start <= 1'b0;
		accepted_count++;
		cycles = 0;
		finished = 1'b0;
		while (!finished) begin
			@(negedge clock);
			cycles++;
			assert (busy)
				else flag_mismatch("busy low while a division is running");
			if (done) begin
				finished = 1'b1;
				assert (quotient == expect_q && overflow == expect_ovf)
					else flag_mismatch($sformatf("%h / %h gave %h ovf %b, expected %h ovf %b",
						num, den, quotient, overflow, expect_q, expect_ovf));
			end else if (cycles >= max_latency) begin
				abort_run("No done within 40 cycles of start");
			end
			@(posedge clock);
			// Starts while busy carry unrelated operands
			if (extra_starts && !finished && (cycles % 5 == 2)) begin
				start <= 1'b1;
				numerator <= $urandom;
				denominator <= random_denominator();
			end else begin
				start <= 1'b0;
			end
		end
		@(negedge clock);
		assert (!busy && !done)
			else flag_mismatch("busy or done still high after done");
	endtask

	initial begin
		logic [31:0] num;
		logic [31:0] den;
		int k;
		void'($urandom(32'h92ee));
		reset = 1'b1;
		start = 1'b0;
		numerator = '0;
		denominator = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		assert (!done && !busy && !overflow && quotient == 32'h0)
			else flag_mismatch("outputs not cleared after reset");

		for (k = 0; k < n_random; k++) begin
			den = random_denominator();
			num = $urandom % den;
			run_division(num, den, 1'b0);
		end

		// Zero numerator
		for (k = 0; k < n_zero; k++) begin
			run_division(32'h0, random_denominator(), 1'b0);
			assert (quotient == 32'h0 && !overflow)
				else flag_mismatch("zero numerator gave nonzero quotient or overflow");
		end

		// Numerators just below the denominator
		for (k = 0; k < n_near; k++) begin
			if (k == 0) begin
				den = 32'h4000_0000;
			end else if (k == 1) begin
				den = 32'h7FFF_FFFF;
			end else begin
				den = random_denominator();
			end
			num = den - 32'd1 - ($urandom % 32'd16);
			run_division(num, den, 1'b0);
		end

		for (k = 0; k < n_busy; k++) begin
			den = random_denominator();
			num = $urandom % den;
			run_division(num, den, 1'b1);
		end

		repeat (4) @(negedge clock);
		assert (done_count == accepted_count)
			else flag_mismatch($sformatf("%0d done strobes for %0d accepted starts",
				done_count, accepted_count));
		if (div32_unit_inst.div32_ctrl_inst.div32_asserts_inst.failures == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			abort_run("Protocol assertion failed in the controller");
		end
	end

endmodule

`default_nettype wire

// ==== tests/div32_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module div32_asserts (
	input logic clock,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done,
	input logic div_start,
	input logic mul_start
);

	localparam logic [5:0] max_latency = 6'd40;

	logic pending;
	logic [5:0] pending_cycles;
	int failures = 0;

	// Cycles since the last accepted start
	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
			pending_cycles <= '0;
		end else if (pending && done) begin
			pending <= 1'b0;
		end else if (!pending && start && !busy) begin
			pending <= 1'b1;
			pending_cycles <= '0;
		end else if (pending) begin
			pending_cycles <= pending_cycles + 6'd1;
		end
	end

	//////////////////////////////
	// Protocol properties
	//////////////////////////////

	done_single_cycle: assert property (@(posedge clock) disable iff (reset) done |=> !done)
		else begin
			failures++;
			$error("done stayed high for more than one cycle");
		end

	starts_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(div_start && mul_start))
		else begin
			failures++;
			$error("div_start and mul_start asserted together");
		end

	busy_until_done: assert property (@(posedge clock) disable iff (reset)
		busy && !done |=> busy)
		else begin
			failures++;
			$error("busy dropped before done");
		end

	// Done must arrive within the latency bound
	done_in_time: assert property (@(posedge clock) disable iff (reset)
		!(pending && pending_cycles >= max_latency))
		else begin
			failures++;
			$error("no done within 40 cycles of an accepted start");
		end

endmodule

`default_nettype wire

// ==== rtl/div32_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module div32_unit (
	input logic clock,
	input logic reset,
	input logic start,
	input logic [31:0] numerator,
	input logic [31:0] denominator,
	output logic busy,
	output logic done,
	output logic [31:0] quotient,
	output logic overflow
);
	import g729_types_pkg::*;

	logic div_start;
	word16_t div_divisor;
	logic div_done;
	word16_t div_quotient;
	logic mul_start;
	logic mul_long;
	dpf_word_u mul_a;
	dpf_word_u mul_b;
	logic mul_done;
	word32_t mul_product;

	basic_op_if op_bus ();

	div32_ctrl div32_ctrl_inst (
		.clock(clock),
		.reset(reset),
		.start(start),
		.numerator(numerator),
		.denominator(denominator),
		.busy(busy),
		.done(done),
		.quotient(quotient),
		.overflow(overflow),
		.div_start(div_start),
		.div_divisor(div_divisor),
		.div_done(div_done),
		.div_quotient(div_quotient),
		.mul_start(mul_start),
		.mul_long(mul_long),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.mul_done(mul_done),
		.mul_product(mul_product)
	);

	div_s_iter div_s_iter_inst (
		.clock(clock),
		.reset(reset),
		.start(div_start),
		.divisor(div_divisor),
		.done(div_done),
		.quotient(div_quotient)
	);

	dpf_mult dpf_mult_inst (
		.clock(clock),
		.reset(reset),
		.start(mul_start),
		.long_mode(mul_long),
		.operand_a(mul_a),
		.operand_b(mul_b),
		.done(mul_done),
		.product(mul_product),
		.op_bus(op_bus.requester)
	);

	basic_op_alu basic_op_alu_inst (
		.alu(op_bus.alu)
	);

endmodule

`default_nettype wire

// ==== rtl/div32_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "g729_cfg.svh"

module div32_ctrl (
	input logic clock,
	input logic reset,
	input logic start,
	input g729_types_pkg::word32_t numerator,
	input g729_types_pkg::word32_t denominator,
	output logic busy,
	output logic done,
	output g729_types_pkg::word32_t quotient,
	output logic overflow,
	output logic div_start,
	output g729_types_pkg::word16_t div_divisor,
	input logic div_done,
	input g729_types_pkg::word16_t div_quotient,
	output logic mul_start,
	output logic mul_long,
	output g729_types_pkg::dpf_word_u mul_a,
	output g729_types_pkg::dpf_word_u mul_b,
	input logic mul_done,
	input g729_types_pkg::word32_t mul_product
);
	import g729_types_pkg::*;

	typedef enum logic [3:0] {
		s_idle,
		s_div,
		s_div_wait,
		s_mul1,
		s_mul1_wait,
		s_sub,
		s_mul2,
		s_mul2_wait,
		s_mul3,
		s_mul3_wait,
		s_done
	} state_e;

	state_e state;
	dpf_word_u num_reg;
	dpf_word_u den_reg;
	dpf_word_u l32_reg;
	word16_t approx;
	word32_t shl_value;
	logic shl_sat;

	// L_sub with saturation
	function automatic word32_t l_sub_sat(input word32_t x, input word32_t y);
		logic [32:0] diff;
		diff = {x[31], x} - {y[31], y};
		if (diff[32] != diff[31])
			return diff[32] ? `G729_MIN_32 : `G729_MAX_32;
		return diff[31:0];
	endfunction

	// L_shl by two saturates unless the top three bits agree
	assign shl_sat = (mul_product[31:29] != 3'b000) && (mul_product[31:29] != 3'b111);
	assign shl_value = !shl_sat ? (mul_product <<< 2) :
		(mul_product[31] ? `G729_MIN_32 : `G729_MAX_32);

	//////////////////////////////
	// Strobes and operands
	//////////////////////////////

	assign busy = (state != s_idle);
	assign done = (state == s_done);
	assign div_start = (state == s_div);
	assign div_divisor = den_reg.ext.hi;
	assign mul_start = (state == s_mul1) || (state == s_mul2) || (state == s_mul3);
	assign mul_long = (state == s_mul3);

	// Approximation goes in as the hi half of the 16-bit operand
	always_comb begin
		mul_a = num_reg;
		mul_b = l32_reg;
		case (state)
			s_mul1: begin
				mul_a = den_reg;
				mul_b.raw = {approx, 16'h0000};
			end
			s_mul2: begin
				mul_a = l32_reg;
				mul_b.raw = {approx, 16'h0000};
			end
			default: begin
				mul_a = num_reg;
			end
		endcase
	end

	//////////////////////////////
	// Sequence
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= s_idle;
			quotient <= '0;
			overflow <= 1'b0;
		end else begin
			case (state)
				s_idle: if (start) state <= s_div;
				s_div: state <= s_div_wait;
				s_div_wait: if (div_done) state <= s_mul1;
				s_mul1: state <= s_mul1_wait;
				s_mul1_wait: if (mul_done) state <= s_sub;
				s_sub: state <= s_mul2;
				s_mul2: state <= s_mul2_wait;
				s_mul2_wait: if (mul_done) state <= s_mul3;
				s_mul3: state <= s_mul3_wait;
				s_mul3_wait: begin
					if (mul_done) begin
						state <= s_done;
						quotient <= shl_value;
						overflow <= shl_sat;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// Intermediate values of the Newton step
	always_ff @(posedge clock) begin
		case (state)
			s_idle: begin
				if (start) begin
					num_reg.raw <= numerator;
					den_reg.raw <= denominator;
				end
			end
			s_div_wait: if (div_done) approx <= div_quotient;
			s_mul1_wait, s_mul2_wait: if (mul_done) l32_reg.raw <= mul_product;
			s_sub: l32_reg.raw <= l_sub_sat(`G729_MAX_32, l32_reg.raw);
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/dpf_mult.sv ====
`timescale 1ns/10ps
`default_nettype none

module dpf_mult (
	input logic clock,
	input logic reset,
	input logic start,
	input logic long_mode,
	input g729_types_pkg::dpf_word_u operand_a,
	input g729_types_pkg::dpf_word_u operand_b,
	output logic done,
	output g729_types_pkg::word32_t product,
	basic_op_if.requester op_bus
);
	import g729_types_pkg::*;
	import basic_op_pkg::*;

	dpf_word_u a_reg;
	dpf_word_u b_reg;
	word16_t a_lo;
	word16_t b_lo;
	word32_t acc_reg;
	word16_t m_reg;
	logic long_reg;
	logic active;
	logic [2:0] step;
	logic last_step;

	// 15-bit low parts are unsigned
	assign a_lo = word16_t'({1'b0, a_reg.ext.lo});
	assign b_lo = word16_t'({1'b0, b_reg.ext.lo});

	// Short mode ends after step 2, long mode after step 4
	assign last_step = long_reg ? (step == 3'd4) : (step == 3'd2);
	assign done = active && last_step;
	assign product = op_bus.result;

	//////////////////////////////
	// Operation schedule
	//////////////////////////////

	// Short  L_mult(hi, n)  mult(lo, n)  L_mac
	// Long   L_mult(hi1, hi2)  mult(hi1, lo2)  L_mac  mult(lo1, hi2)  L_mac
	always_comb begin
		op_bus.op = op_l_mult;
		op_bus.a = a_reg.ext.hi;
		op_bus.b = b_reg.ext.hi;
		op_bus.acc = acc_reg;
		case (step)
			3'd1: begin
				op_bus.op = op_mult;
				if (long_reg) begin
					op_bus.b = b_lo;
				end else begin
					op_bus.a = a_lo;
				end
			end
			3'd2, 3'd4: begin
				op_bus.op = op_l_mac;
				op_bus.a = m_reg;
				op_bus.b = 16'sd1;
			end
			3'd3: begin
				op_bus.op = op_mult;
				op_bus.a = a_lo;
			end
			default: begin
				op_bus.op = op_l_mult;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			step <= '0;
		end else if (active) begin
			if (last_step) begin
				active <= 1'b0;
				step <= '0;
			end else begin
				step <= step + 3'd1;
			end
		end else if (start) begin
			active <= 1'b1;
			step <= '0;
		end
	end

	// Operands and partial results
	always_ff @(posedge clock) begin
		if (!active && start) begin
			a_reg <= operand_a;
			b_reg <= operand_b;
			long_reg <= long_mode;
		end
		if (active) begin
			if (step == 3'd1 || step == 3'd3) begin
				m_reg <= op_bus.result[15:0];
			end else begin
				acc_reg <= op_bus.result;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/div_s_iter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "g729_cfg.svh"

module div_s_iter (
	input logic clock,
	input logic reset,
	input logic start,
	input g729_types_pkg::word16_t divisor,
	output logic done,
	output g729_types_pkg::word16_t quotient
);
	import g729_types_pkg::*;

	localparam logic [3:0] last_count = 4'(`G729_DIV_BITS - 1);

	word16_t divisor_reg;
	logic [15:0] remainder;
	logic [16:0] trial;
	logic trial_fits;
	logic [3:0] count;
	logic active;

	// Remainder stays below the divisor so one extra bit is enough
	assign trial = {remainder, 1'b0};
	assign trial_fits = (trial >= {1'b0, divisor_reg});

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (active) begin
				count <= count + 4'd1;
				if (count == last_count) begin
					active <= 1'b0;
					done <= 1'b1;
				end
			end else if (start) begin
				active <= 1'b1;
				count <= '0;
			end
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////

	// One restoring step per cycle, quotient bits enter from the right
	always_ff @(posedge clock) begin
		if (active) begin
			remainder <= trial_fits ? 16'(trial - {1'b0, divisor_reg}) : trial[15:0];
			quotient <= {quotient[14:0], trial_fits};
		end else if (start) begin
			divisor_reg <= divisor;
			remainder <= `G729_RECIP_SEED;
			quotient <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/basic_op_alu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "g729_cfg.svh"

module basic_op_alu (
	basic_op_if.alu alu
);
	import g729_types_pkg::*;
	import basic_op_pkg::*;

	word32_t product;
	word32_t l_mult_value;
	logic l_mult_sat;
	logic [32:0] mac_sum;
	logic mac_sat;
	logic mult_sat;

	// One 16x16 signed multiplier for every operation
	assign product = word32_t'(alu.a) * word32_t'(alu.b);

	// Only -32768 * -32768 leaves the Q31 range once doubled
	assign l_mult_sat = (product == 32'sh4000_0000);
	assign l_mult_value = l_mult_sat ? `G729_MAX_32 : (product <<< 1);

	// Accumulate with one guard bit
	assign mac_sum = {alu.acc[31], alu.acc} + {l_mult_value[31], l_mult_value};
	assign mac_sat = mac_sum[32] ^ mac_sum[31];

	// Product >> 15 fits in 16 bits unless bits 31 and 30 differ
	assign mult_sat = product[31] ^ product[30];

	always_comb begin
		alu.result = '0;
		alu.overflow = 1'b0;
		case (alu.op)
			op_l_mult: begin
				alu.result = l_mult_value;
				alu.overflow = l_mult_sat;
			end
			op_l_mac: begin
				if (mac_sat) begin
					alu.result = mac_sum[32] ? `G729_MIN_32 : `G729_MAX_32;
				end else begin
					alu.result = mac_sum[31:0];
				end
				alu.overflow = l_mult_sat | mac_sat;
			end
			op_mult: begin
				if (mult_sat) begin
					alu.result = {16'h0000, `G729_MAX_16};
				end else begin
					// Sign extended so the requester may use either half
					alu.result = {{16{product[30]}}, product[30:15]};
				end
				alu.overflow = mult_sat;
			end
			default: begin
				alu.result = '0;
				alu.overflow = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/basic_op_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface basic_op_if;
	import g729_types_pkg::*;
	import basic_op_pkg::*;

	basic_op_e op;
	word16_t a;
	word16_t b;
	word32_t acc;
	word32_t result;
	logic overflow;

	// Side that issues one operation per cycle
	modport requester (
		output op,
		output a,
		output b,
		output acc,
		input result,
		input overflow
	);

	// Combinational operator unit
	modport alu (
		input op,
		input a,
		input b,
		input acc,
		output result,
		output overflow
	);

endinterface

`default_nettype wire

// ==== rtl/basic_op_pkg.sv ====
`default_nettype none

package basic_op_pkg;

	//////////////////////////////
	// Basic operator codes
	//////////////////////////////

	// L_mult  a * b * 2 saturated to 32 bits
	// L_mac   acc + L_mult(a, b) saturated
	// mult    (a * b) >> 15 saturated to 16 bits
	typedef enum logic [1:0] {
		op_l_mult = 2'd0,
		op_l_mac = 2'd1,
		op_mult = 2'd2
	} basic_op_e;

endpackage

`default_nettype wire

// ==== rtl/g729_types_pkg.sv ====
`default_nettype none

package g729_types_pkg;

	// Q15 fraction
	typedef logic signed [15:0] word16_t;

	// Q31 fraction
	typedef logic signed [31:0] word32_t;

	//////////////////////////////
	// Double precision format
	//////////////////////////////

	// A 32-bit word seen either raw or split the way L_Extract splits it.
	// hi is the upper half, lo holds bits 15..1, bit 0 is lost.
	typedef union packed {
		word32_t raw;
		struct packed {
			word16_t hi;
			logic [14:0] lo;
			logic dropped;
		} ext;
	} dpf_word_u;

endpackage

`default_nettype wire

// ==== include/g729_cfg.svh ====
`ifndef G729_CFG_SVH
`define G729_CFG_SVH

// Saturation limits of the codec's basic operations
`define G729_MAX_32 32'sh7FFF_FFFF
`define G729_MIN_32 32'sh8000_0000
`define G729_MAX_16 16'sh7FFF

// Seed division 0x3FFF / denominator_hi
`define G729_RECIP_SEED 16'h3FFF

// Quotient bits produced by the seed division
`define G729_DIV_BITS 15

`endif
